/* fx_cluster.f */
+incdir+design
design/fx_uop_pkg.sv
design/fx_bus_pkg.sv
design/fx_operand_fwd.sv
design/fx_add_lane.sv
design/fx_shift_lane.sv
design/fx_cluster.sv
sim/tb_fx_cluster.sv

/* Makefile */
# Verilator build and run for the integer execution cluster

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --top-module tb_fx_cluster -f fx_cluster.f
	@out="$$(./obj_dir/Vtb_fx_cluster)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir

/* sim/fx_input.txt */
// v0 op0 hi0 a0 b0 imm0 af0 bf0 tag0 v1 op1 hi1 a1 b1 af1 bf1 tag1 ext0 ext1 exp0 exp1
// hi: {spare,wide} or lea scale; fwd 0 rf, 1-4 bus now, 5-8 bus one cycle old
1 01 1 5 7 0 0 0 01 1 10 1 1 3f 0 0 02 0 0 c 8000000000000000
1 02 1 10 30 0 0 0 03 0 0 0 0 0 0 0 0 1111 2222 ffffffffffffffe0 0
1 03 1 ff00ff00ff00ff00 ffff0000 0 0 0 04 1 11 1 0 4 2 0 05 3333 4444 ff000000 800000000000000
1 04 1 0 30 0 5 0 06 0 0 0 0 0 0 0 0 5555 6666 3c 0
1 05 1 0 ffffffffffffffff 0 1 0 07 1 12 1 0 4 3 0 08 8000000000000000 0 ffffffff00ffffff f800000000000000
1 01 0 fffffff0 20 0 0 0 09 1 12 0 1234567880000000 4 0 0 0a 0 0 10 f8000000
1 02 0 1 2 0 0 0 0b 1 10 0 3 21 0 0 0c 0 0 ffffffff 6
1 06 0 1000 10 20 0 0 0d 1 11 0 ffffffff00000080 27 0 0 0e 0 0 1030 1
1 06 3 1000 10 fffffff0 0 0 0f 1 10 1 1 41 0 0 10 0 0 1070 2
1 06 1 0 4 80000000 1 0 11 1 12 1 0 1 6 0 12 0 f000000000000000 ffffffff80001038 3
1 06 2 100 0 ffffffff 0 4 13 1 11 1 0 3c 8 0 14 123 40 1ff f
1 01 1 0 100 0 7 9 15 1 10 1 5 2 f c 16 ffff 0 223 14
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 01 1 1 1 0 0 0 20 1 10 1 1 1 0 0 21 0 0 2 2
1 01 1 10 10 0 0 0 22 1 10 1 3 2 0 0 23 0 0 20 c
1 01 1 0 0 0 1 2 24 1 10 1 0 4 1 0 25 0 0 4 20
1 01 1 0 0 0 1 5 26 1 11 1 0 0 2 6 27 0 0 22 3
1 02 1 0 0 0 1 2 28 1 10 0 0 0 5 2 29 0 0 ffffffffffffffe4 20
1 05 1 0 0 0 1 6 2a 1 12 1 0 0 1 2 2b 0 0 2 4
1 01 0 0 20 0 1 0 2c 1 12 0 0 2 1 0 2d 0 0 4 fffffff9

/* sim/tb_fx_cluster.sv */
//**************************************************************************
// Testbench for the integer execution cluster. Replays the input file one
// issue cycle per line and checks both result buses two edges later
//**************************************************************************

`timescale 1ns/1ps

`include "fx_settings.svh"

module tb_fx_cluster
  import fx_bus_pkg::*, fx_uop_pkg::*;
();

  localparam int LINES      = 20;
  localparam int FIELDS     = 21;  // Words per line in the input file
  localparam int RST_CYCLES = 16;
  localparam int MAX_CYCLES = RST_CYCLES + LINES + 10;

  logic                 clk;
  logic                 arst_n;
  logic                 lane0_valid;
  uop_u                 lane0_uop;
  data_t                lane0_a;
  data_t                lane0_b;
  logic [`FX_IMM_W-1:0] lane0_imm;
  fwd_sel_t             lane0_a_fwd;
  fwd_sel_t             lane0_b_fwd;
  tag_t                 lane0_tag;
  logic                 lane1_valid;
  uop_u                 lane1_uop;
  data_t                lane1_a;
  data_t                lane1_b;
  fwd_sel_t             lane1_a_fwd;
  fwd_sel_t             lane1_b_fwd;
  tag_t                 lane1_tag;
  data_t                ext_res0;
  data_t                ext_res1;
  data_t                lane0_res;
  logic                 lane0_res_valid;
  tag_t                 lane0_res_tag;
  data_t                lane1_res;
  logic                 lane1_res_valid;
  tag_t                 lane1_res_tag;

  logic [63:0] stim [0:LINES*FIELDS-1];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          ops    = 0;

  fx_cluster fx_cluster_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // Lines past the end of the file act as idle cycles
  task automatic drive_line(input int ln);
    logic [63:0] w [0:FIELDS-1];
    for (int i = 0; i < FIELDS; i++) begin
      if (ln < LINES) begin
        w[i] = stim[ln * FIELDS + i];
      end else begin
        w[i] = '0;
      end
    end
    lane0_valid <= w[0][0];
    lane0_uop   <= {w[2][1:0], w[1][7:0]};
    lane1_valid <= w[9][0];
    lane1_uop   <= {w[11][1:0], w[10][7:0]};
    ext_res0    <= w[17];
    ext_res1    <= w[18];
    if (w[0][0]) begin
      lane0_a     <= w[3];
      lane0_b     <= w[4];
      lane0_imm   <= w[5][31:0];
      lane0_a_fwd <= w[6][3:0];
      lane0_b_fwd <= w[7][3:0];
      lane0_tag   <= w[8][5:0];
    end else begin  // Noise on an idle lane
      lane0_a     <= {$urandom, $urandom};
      lane0_b     <= {$urandom, $urandom};
      lane0_imm   <= $urandom;
      lane0_a_fwd <= 4'($urandom);
      lane0_b_fwd <= 4'($urandom);
      lane0_tag   <= 6'($urandom);
    end
    if (w[9][0]) begin
      lane1_a     <= w[12];
      lane1_b     <= w[13];
      lane1_a_fwd <= w[14][3:0];
      lane1_b_fwd <= w[15][3:0];
      lane1_tag   <= w[16][5:0];
    end else begin
      lane1_a     <= {$urandom, $urandom};
      lane1_b     <= {$urandom, $urandom};
      lane1_a_fwd <= 4'($urandom);
      lane1_b_fwd <= 4'($urandom);
      lane1_tag   <= 6'($urandom);
    end
  endtask

  task automatic check_line(input int ln);
    logic [63:0] w [0:FIELDS-1];
    for (int i = 0; i < FIELDS; i++) begin
      w[i] = stim[ln * FIELDS + i];
    end
    compare_value("lane0_res_valid", 64'(w[0][0]), 64'(lane0_res_valid));
    compare_value("lane1_res_valid", 64'(w[9][0]), 64'(lane1_res_valid));
    if (w[0][0]) begin
      compare_value("lane0_res", w[19], lane0_res);
      compare_value("lane0_res_tag", 64'(w[8][5:0]), 64'(lane0_res_tag));
    end
    if (w[9][0]) begin
      compare_value("lane1_res", w[20], lane1_res);
      compare_value("lane1_res_tag", 64'(w[16][5:0]), 64'(lane1_res_tag));
    end
  endtask

  initial begin
    void'($urandom(79));
    $readmemh("sim/fx_input.txt", stim);
    for (int i = 0; i < LINES; i++) begin
      ops += int'(stim[i * FIELDS][0]) + int'(stim[i * FIELDS + 9][0]);
    end
    arst_n <= 1'b0;
    drive_line(LINES);
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    // An op driven at loop step c shows on the buses at step c+2
    for (int c = 0; c < LINES + 2; c++) begin
      @(posedge clk);
      drive_line(c);
      @(negedge clk);
      if (c >= 2) begin
        check_line(c - 2);
      end else begin
        compare_value("lane0_res_valid", 64'd0, 64'(lane0_res_valid));
        compare_value("lane1_res_valid", 64'd0, 64'(lane1_res_valid));
      end
    end

    assert (ops > 0) else begin
      errors++;
      $display("the input file held no valid operation");
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* design/fx_cluster.sv */
//**************************************************************************
// Two-lane integer execution cluster. Lane 0 adds, lane 1 shifts; both
// take operands from the register file or any of the four result buses
//**************************************************************************

`timescale 1ns/1ps

`include "fx_settings.svh"

module fx_cluster
  import fx_bus_pkg::*, fx_uop_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 lane0_valid,
  input  uop_u                 lane0_uop,
  input  data_t                lane0_a,
  input  data_t                lane0_b,
  input  logic [`FX_IMM_W-1:0] lane0_imm,
  input  fwd_sel_t             lane0_a_fwd,
  input  fwd_sel_t             lane0_b_fwd,
  input  tag_t                 lane0_tag,
  input  logic                 lane1_valid,
  input  uop_u                 lane1_uop,
  input  data_t                lane1_a,
  input  data_t                lane1_b,
  input  fwd_sel_t             lane1_a_fwd,
  input  fwd_sel_t             lane1_b_fwd,
  input  tag_t                 lane1_tag,
  input  data_t                ext_res0,
  input  data_t                ext_res1,
  output data_t                lane0_res,
  output logic                 lane0_res_valid,
  output tag_t                 lane0_res_tag,
  output data_t                lane1_res,
  output logic                 lane1_res_valid,
  output tag_t                 lane1_res_tag
);

  bus_vec_t buses;
  data_t    l0_a, l0_b, l1_a, l1_b;

  assign buses = {ext_res1, ext_res0, lane1_res, lane0_res};  // Bus 0 in the low word

  fx_operand_fwd l0_a_fwd_i (.clk, .arst_n, .rf_val(lane0_a), .fwd(lane0_a_fwd),
                             .buses, .opnd(l0_a));
  fx_operand_fwd l0_b_fwd_i (.clk, .arst_n, .rf_val(lane0_b), .fwd(lane0_b_fwd),
                             .buses, .opnd(l0_b));
  fx_operand_fwd l1_a_fwd_i (.clk, .arst_n, .rf_val(lane1_a), .fwd(lane1_a_fwd),
                             .buses, .opnd(l1_a));
  fx_operand_fwd l1_b_fwd_i (.clk, .arst_n, .rf_val(lane1_b), .fwd(lane1_b_fwd),
                             .buses, .opnd(l1_b));

  fx_add_lane add_lane_i (
    .clk, .arst_n, .valid(lane0_valid), .uop(lane0_uop), .imm(lane0_imm),
    .tag(lane0_tag), .a(l0_a), .b(l0_b),
    .res(lane0_res), .res_valid(lane0_res_valid), .res_tag(lane0_res_tag)
  );

  fx_shift_lane shift_lane_i (
    .clk, .arst_n, .valid(lane1_valid), .uop(lane1_uop),
    .tag(lane1_tag), .a(l1_a), .b(l1_b),
    .res(lane1_res), .res_valid(lane1_res_valid), .res_tag(lane1_res_tag)
  );

endmodule

/* design/fx_shift_lane.sv */
//**************************************************************************
// Shift lane: shl, shr and sar at 32 or 64 bits, counts taken modulo the
// width. Same two-edge timing as the adder lane
//**************************************************************************

`timescale 1ns/1ps

`include "fx_settings.svh"

module fx_shift_lane
  import fx_bus_pkg::*, fx_uop_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  valid,
  input  uop_u  uop,
  input  tag_t  tag,
  input  data_t a,
  input  data_t b,
  output data_t res,
  output logic  res_valid,
  output tag_t  res_tag
);

  localparam int CNT_W  = $clog2(`FX_DATA_W);
  localparam int HCNT_W = $clog2(`FX_HALF_W);

  uop_u uop_q;
  tag_t tag_q;
  logic valid_q;

  logic                  dir_right;
  logic                  arith;
  logic [CNT_W-1:0]      cnt_w;
  logic [HCNT_W-1:0]     cnt_h;
  logic [`FX_HALF_W-1:0] lo;
  logic [`FX_HALF_W-1:0] lo_r;
  data_t                 wide_r;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid;
    end
  end

  always_ff @(posedge clk) begin
    uop_q <= uop;
    tag_q <= tag;
  end

  assign dir_right = uop_q.alu.opcode != op_shl;
  assign arith     = uop_q.alu.opcode == op_sar;
  assign cnt_w     = b[CNT_W-1:0];   // Modulo 64
  assign cnt_h     = b[HCNT_W-1:0];  // Modulo 32
  assign lo        = a[`FX_HALF_W-1:0];

  always_comb begin
    if (!dir_right) begin
      wide_r = a << cnt_w;
      lo_r   = lo << cnt_h;
    end else if (arith) begin
      wide_r = $signed(a) >>> cnt_w;
      lo_r   = $signed(lo) >>> cnt_h;  // Fill from bit 31
    end else begin
      wide_r = a >> cnt_w;
      lo_r   = lo >> cnt_h;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res       <= '0;
      res_valid <= 1'b0;
      res_tag   <= '0;
    end else begin
      res_valid <= valid_q;
      if (valid_q) begin
        res     <= uop_q.alu.wide ? wide_r : {{(`FX_DATA_W - `FX_HALF_W){1'b0}}, lo_r};
        res_tag <= tag_q;
      end
    end
  end

endmodule

/* design/fx_add_lane.sv */
//**************************************************************************
// Adder lane: add, sub and logic ops at 32 or 64 bits, plus address
// generation. Issue registers at edge N, result on the bus after N+1
//**************************************************************************

`timescale 1ns/1ps

`include "fx_settings.svh"

module fx_add_lane
  import fx_bus_pkg::*, fx_uop_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 valid,
  input  uop_u                 uop,
  input  logic [`FX_IMM_W-1:0] imm,
  input  tag_t                 tag,
  input  data_t                a,
  input  data_t                b,
  output data_t                res,
  output logic                 res_valid,
  output tag_t                 res_tag
);

  uop_u                 uop_q;
  logic [`FX_IMM_W-1:0] imm_q;
  tag_t                 tag_q;
  logic                 valid_q;

  data_t alu_r;
  data_t imm_ext;
  data_t ea;
  data_t res_d;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid;
    end
  end

  always_ff @(posedge clk) begin
    uop_q <= uop;
    imm_q <= imm;
    tag_q <= tag;
  end

  always_comb begin
    case (uop_q.alu.opcode)
      op_sub:  alu_r = a - b;
      op_and:  alu_r = a & b;
      op_or:   alu_r = a | b;
      op_xor:  alu_r = a ^ b;
      default: alu_r = a + b;
    endcase
  end

  // Effective address is always full width
  assign imm_ext = {{(`FX_DATA_W - `FX_IMM_W){imm_q[`FX_IMM_W-1]}}, imm_q};
  assign ea      = a + (b << uop_q.agu.scale) + imm_ext;

  always_comb begin
    if (uop_q.agu.opcode == op_lea) begin
      res_d = ea;
    end else if (uop_q.alu.wide) begin
      res_d = alu_r;
    end else begin
      res_d = {{(`FX_DATA_W - `FX_HALF_W){1'b0}}, alu_r[`FX_HALF_W-1:0]};  // Zero-extend
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res       <= '0;
      res_valid <= 1'b0;
      res_tag   <= '0;
    end else begin
      res_valid <= valid_q;
      if (valid_q) begin
        res     <= res_d;
        res_tag <= tag_q;
      end
    end
  end

endmodule

/* design/fx_operand_fwd.sv */
//**************************************************************************
// Source operand select for one lane input. Picks the register file value
// or a result bus, current or one cycle old, and registers it at issue
//**************************************************************************

`timescale 1ns/1ps

`include "fx_settings.svh"

module fx_operand_fwd
  import fx_bus_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  data_t    rf_val,
  input  fwd_sel_t fwd,
  input  bus_vec_t buses,
  output data_t    opnd
);

  localparam int BUS_N = `FX_BUS_N;

  bus_vec_t bus_q;   // Bus values seen one edge ago
  data_t    sel;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bus_q <= '0;
    end else begin
      bus_q <= buses;
    end
  end

  always_comb begin
    sel = rf_val;
    if (fwd >= 4'd1 && fwd <= 4'(BUS_N)) begin
      sel = buses[2'(fwd - 4'd1)];
    end else if (fwd > 4'(BUS_N) && fwd <= 4'(2 * BUS_N)) begin
      // Previous cycle view, zero right after reset
      sel = bus_q[2'(fwd - 4'(BUS_N + 1))];
    end
  end

  always_ff @(posedge clk) begin
    opnd <= sel;
  end

endmodule

/* design/fx_bus_pkg.sv */
//**************************************************************************
// Result bus types: data word, tag, bus vector and operand forward select
//**************************************************************************

`include "fx_settings.svh"

package fx_bus_pkg;

  typedef logic [`FX_DATA_W-1:0] data_t;
  typedef logic [`FX_TAG_W-1:0]  tag_t;

  // 0 selects the register file value
  // 1..4 bus 0..3 this cycle, 5..8 bus 0..3 one cycle back
  // Higher codes fall back to the register file value
  typedef logic [3:0] fwd_sel_t;

  // Bus 0 adder lane, bus 1 shift lane, buses 2 and 3 external
  typedef data_t [`FX_BUS_N-1:0] bus_vec_t;

endpackage

/* design/fx_uop_pkg.sv */
//**************************************************************************
// Micro-op word types. The word above the opcode is read as width by the
// arithmetic and shift paths and as index scale by address generation
//**************************************************************************

`include "fx_settings.svh"

package fx_uop_pkg;

  typedef enum logic [`FX_OPC_W-1:0] {
    op_add = 8'h01,
    op_sub = 8'h02,
    op_and = 8'h03,
    op_or  = 8'h04,
    op_xor = 8'h05,
    op_lea = 8'h06,  // Base plus scaled index plus constant
    op_shl = 8'h10,
    op_shr = 8'h11,
    op_sar = 8'h12
  } opcode_t;

  typedef struct packed {
    logic    spare;
    logic    wide;    // Set for 64-bit operation
    opcode_t opcode;
  } alu_view_t;

  typedef struct packed {
    logic [1:0] scale;  // Index shift 0 to 3
    opcode_t    opcode;
  } agu_view_t;

  typedef union packed {
    alu_view_t alu;
    agu_view_t agu;
  } uop_u;

endpackage

/* design/fx_settings.svh */
//**************************************************************************
// Widths and counts for the integer execution cluster, shared by the RTL
// packages and the testbench
//**************************************************************************

`ifndef FX_SETTINGS_SVH
`define FX_SETTINGS_SVH

`define FX_DATA_W 64   // Result bus word
`define FX_HALF_W 32   // Narrow operation width
`define FX_IMM_W  32   // Address constant, sign-extended
`define FX_TAG_W  6
`define FX_OPC_W  8

// Two lane buses plus two external buses
`define FX_BUS_N  4

`endif
